/* render_manager.f */
render_pkg.sv
screen_filler.sv
triangle_setup.sv
edge_walker.sv
render_manager.sv
render_checker.sv
render_monitor.sv
render_tb.sv

/* render_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module render_tb;
    import render_pkg::*;

    localparam int N = 9;

    logic                  clk, rst, begin_frame, fill_valid, triangle_valid, out_ready;
    logic [COLOR_BITS-1:0] fill_color, tri_color;
    logic [COORD_BITS-1:0] tri_x0, tri_y0, tri_x1, tri_y1, tri_x2, tri_y2;
    logic [DEPTH_BITS-1:0] tri_depth;
    wire logic             fill_ready, triangle_ready, out_compare_depth, out_valid, busy;
    wire logic [COORD_BITS-1:0] out_pixel_x, out_pixel_y;
    wire logic [DEPTH_BITS-1:0] out_depth;
    wire logic [COLOR_BITS-1:0] out_color;

    logic [31:0] rng = 32'd28333;
    int          watchdog_cycles = 0;

    // kind (0 fill, 1 triangle), colour, depth, x0, y0, x1, y1, x2, y2, pixels, wait for idle
    int stim [N][11] = '{
        '{0, 'hF80, 0, 0, 0, 0, 0, 0, 0, 192, 1},
        '{1, 'h0F0, 100, 2, 1, 10, 1, 2, 9, 45, 1},
        '{1, 'h00F, 200, 2, 1, 2, 9, 10, 1, BACKFACE_CULLING ? 0 : 45, 1},  // clockwise
        '{1, 'hFFF, 300, 0, 0, 5, 5, 10, 10, 0, 1},
        '{1, 'h888, 400, 8, 4, 20, 4, 8, 16, 61, 1},  // clipped at the right and bottom
        '{0, 'h00F, 0, 0, 0, 0, 0, 0, 0, 192, 1},
        '{1, 'hF0F, 500, 0, 0, 15, 0, 0, 11, 97, 0},
        '{1, 'h0FF, 600, 15, 0, 15, 11, 0, 11, 97, 1},
        '{1, 'h123, 700, 20, 20, 30, 20, 20, 30, 0, 1}
    };

    render_manager uut (.*);
    render_monitor mon (.*);

    bind render_manager render_checker chk (
        .clk(clk), .rst(rst), .out_valid(out_valid), .out_ready(out_ready),
        .out_pixel_x(out_pixel_x), .out_pixel_y(out_pixel_y), .out_depth(out_depth),
        .out_color(out_color), .out_compare_depth(out_compare_depth)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    always @(posedge clk) begin
        #1;
        rng = xorshift(rng);
        out_ready = (rng[1:0] != 2'b00);  // ready about three cycles in four
    end

    function automatic int extent(input int a, input int b, input int c);
        int lo;
        int hi;
        lo = (a < b) ? a : b;
        lo = (c < lo) ? c : lo;
        hi = (a > b) ? a : b;
        hi = (c > hi) ? c : hi;
        return hi - lo + 1;
    endfunction

    task automatic wait_for_idle();
        do @(negedge clk); while (busy || !triangle_ready);
    endtask

    task automatic end_run(input bit timed_out);
        int failures;
        failures = mon.mismatch_count + mon.other_count + uut.chk.fail_count;
        $display("done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mon.mismatch_count, mon.other_count, uut.chk.fail_count);
        if (timed_out || failures != 0) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        end_run(1'b1);
    end

    initial begin
        int expected;
        int worst;
        rst = 1'b1;
        begin_frame = 1'b0;
        fill_color = '0;
        fill_valid = 1'b0;
        {tri_x0, tri_y0, tri_x1, tri_y1, tri_x2, tri_y2} = '0;
        tri_color = '0;
        tri_depth = '0;
        triangle_valid = 1'b0;
        out_ready = 1'b0;
        worst = SCREEN_W * SCREEN_H + 20;  // the fill after reset
        for (int i = 0; i < N; i++) begin
            if (stim[i][0] == 0) worst += SCREEN_W * SCREEN_H + 20;
            else worst += extent(stim[i][3], stim[i][5], stim[i][7])
                          * extent(stim[i][4], stim[i][6], stim[i][8]) + 20;
        end
        watchdog_cycles = 2 * worst;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        expected = SCREEN_W * SCREEN_H;
        wait_for_idle();
        mon.check_idle(expected);
        for (int i = 0; i < N; i++) begin
            @(posedge clk);
            #1;
            if (stim[i][0] == 0) begin
                begin_frame = 1'b1;
                fill_valid = 1'b1;
                fill_color = COLOR_BITS'(stim[i][1]);
                @(posedge clk);
                #1;
                begin_frame = 1'b0;
                fill_valid = 1'b0;
            end else begin
                tri_color = COLOR_BITS'(stim[i][1]);
                tri_depth = DEPTH_BITS'(stim[i][2]);
                tri_x0 = COORD_BITS'(stim[i][3]);
                tri_y0 = COORD_BITS'(stim[i][4]);
                tri_x1 = COORD_BITS'(stim[i][5]);
                tri_y1 = COORD_BITS'(stim[i][6]);
                tri_x2 = COORD_BITS'(stim[i][7]);
                tri_y2 = COORD_BITS'(stim[i][8]);
                triangle_valid = 1'b1;
                @(negedge clk);
                while (!triangle_ready) @(negedge clk);
                @(posedge clk);
                #1;
                triangle_valid = 1'b0;
            end
            expected += stim[i][9];
            if (stim[i][10] != 0) begin
                wait_for_idle();
                mon.check_idle(expected);
            end
        end
        end_run(1'b0);
    end

endmodule

`default_nettype wire

/* render_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module render_monitor (
    input wire logic                              clk,
    input wire logic                              rst,
    input wire logic                              begin_frame,
    input wire logic [render_pkg::COLOR_BITS-1:0] fill_color,
    input wire logic                              fill_valid,
    input wire logic                              fill_ready,
    input wire logic [render_pkg::COORD_BITS-1:0] tri_x0,
    input wire logic [render_pkg::COORD_BITS-1:0] tri_y0,
    input wire logic [render_pkg::COORD_BITS-1:0] tri_x1,
    input wire logic [render_pkg::COORD_BITS-1:0] tri_y1,
    input wire logic [render_pkg::COORD_BITS-1:0] tri_x2,
    input wire logic [render_pkg::COORD_BITS-1:0] tri_y2,
    input wire logic [render_pkg::COLOR_BITS-1:0] tri_color,
    input wire logic [render_pkg::DEPTH_BITS-1:0] tri_depth,
    input wire logic                              triangle_valid,
    input wire logic                              triangle_ready,
    input wire logic [render_pkg::COORD_BITS-1:0] out_pixel_x,
    input wire logic [render_pkg::COORD_BITS-1:0] out_pixel_y,
    input wire logic [render_pkg::DEPTH_BITS-1:0] out_depth,
    input wire logic [render_pkg::COLOR_BITS-1:0] out_color,
    input wire logic                              out_compare_depth,
    input wire logic                              out_valid,
    input wire logic                              out_ready,
    input wire logic                              busy
);
    import render_pkg::*;

    int mismatch_count = 0;
    int other_count = 0;
    int pixel_count = 0;
    int fill_left = 0;   // fill pixels still owed to the screen
    int fill_model = 0;  // mirrors the fill colour register
    int qx[$], qy[$], qc[$], qd[$], qm[$];

    function automatic int edge_fn(input int ax, input int ay, input int bx, input int by,
                                   input int px, input int py);
        return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
    endfunction

    task automatic push(input int x, input int y, input int c, input int d, input int m);
        qx.push_back(x);
        qy.push_back(y);
        qc.push_back(c);
        qd.push_back(d);
        qm.push_back(m);
    endtask

    task automatic add_fill(input int color);
        for (int y = 0; y < SCREEN_H; y++) begin
            for (int x = 0; x < SCREEN_W; x++) begin
                push(x, y, color, DEPTH_FAR, 0);
            end
        end
        fill_left += SCREEN_W * SCREEN_H;
    endtask

    task automatic add_triangle(input int x0, input int y0, input int x1, input int y1,
                                input int x2, input int y2, input int c, input int d);
        int area;
        int t;
        int xl, xh, yl, yh;
        area = edge_fn(x0, y0, x1, y1, x2, y2);
        if (area < 0 && !BACKFACE_CULLING) begin
            t = x1;
            x1 = x2;
            x2 = t;
            t = y1;
            y1 = y2;
            y2 = t;
            area = -area;
        end
        if (area <= 0) return;  // clockwise or degenerate
        xl = (x0 < x1) ? x0 : x1;
        xl = (x2 < xl) ? x2 : xl;
        yl = (y0 < y1) ? y0 : y1;
        yl = (y2 < yl) ? y2 : yl;
        xh = (x0 > x1) ? x0 : x1;
        xh = (x2 > xh) ? x2 : xh;
        yh = (y0 > y1) ? y0 : y1;
        yh = (y2 > yh) ? y2 : yh;
        if (xh > SCREEN_W - 1) xh = SCREEN_W - 1;
        if (yh > SCREEN_H - 1) yh = SCREEN_H - 1;
        for (int y = yl; y <= yh; y++) begin
            for (int x = xl; x <= xh; x++) begin
                if (edge_fn(x0, y0, x1, y1, x, y) >= 0 && edge_fn(x1, y1, x2, y2, x, y) >= 0
                    && edge_fn(x2, y2, x0, y0, x, y) >= 0) begin
                    push(x, y, c, d, 1);
                end
            end
        end
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch at %0t ns: %s expected 0x%0h got 0x%0h",
                     $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    // called by the testbench once the DUT has gone idle
    task automatic check_idle(input int expected_total);
        if (qx.size() != 0) begin
            $display("%0d expected pixels never appeared by %0t ns", qx.size(), $time);
            other_count++;
        end
        if (pixel_count != expected_total) begin
            $display("%0d pixels came out where the stimulus table expects %0d",
                     pixel_count, expected_total);
            other_count++;
        end
    endtask

    // sampling at the falling edge sees every handshake signal settled
    always @(negedge clk) begin
        int m;
        if (rst) begin
            qx.delete();
            qy.delete();
            qc.delete();
            qd.delete();
            qm.delete();
            fill_left = 0;
            fill_model = 0;
            pixel_count = 0;
            add_fill(0);  // the screen is cleared again right after reset
        end else begin
            compare("fill_ready", 32'd1, fill_ready);  // the fill colour port never stalls
            if (!busy && qx.size() != 0) begin
                $display("busy is low at %0t ns while %0d pixels are still expected",
                         $time, qx.size());
                other_count++;
            end
            if (triangle_ready && fill_left != 0) begin
                $display("triangle_ready is high at %0t ns before the fill finished", $time);
                other_count++;
            end
            if (out_valid && out_ready) begin
                pixel_count++;
                if (qx.size() == 0) begin
                    $display("an unexpected pixel at %0d,%0d came out at %0t ns",
                             out_pixel_x, out_pixel_y, $time);
                    other_count++;
                end else begin
                    m = qm.pop_front();
                    compare("out_pixel_x", qx.pop_front(), out_pixel_x);
                    compare("out_pixel_y", qy.pop_front(), out_pixel_y);
                    compare("out_color", qc.pop_front(), out_color);
                    compare("out_depth", qd.pop_front(), out_depth);
                    compare("out_compare_depth", m, out_compare_depth);
                    if (m == 0) fill_left--;
                end
            end
            if (fill_valid && fill_ready) fill_model = fill_color;
            if (begin_frame) add_fill(fill_model);
            if (triangle_valid && triangle_ready) begin
                add_triangle(tri_x0, tri_y0, tri_x1, tri_y1, tri_x2, tri_y2,
                             tri_color, tri_depth);
            end
        end
    end

endmodule

`default_nettype wire

/* render_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module render_checker (
    input wire logic                              clk,
    input wire logic                              rst,
    input wire logic                              out_valid,
    input wire logic                              out_ready,
    input wire logic [render_pkg::COORD_BITS-1:0] out_pixel_x,
    input wire logic [render_pkg::COORD_BITS-1:0] out_pixel_y,
    input wire logic [render_pkg::DEPTH_BITS-1:0] out_depth,
    input wire logic [render_pkg::COLOR_BITS-1:0] out_color,
    input wire logic                              out_compare_depth
);
    import render_pkg::*;

    int fail_count = 0;

    a_quiet_in_reset: assert property (@(posedge clk) rst |-> !out_valid)
        else begin
            $error("out_valid is high while rst is high");
            fail_count++;
        end

    // a stalled pixel must not move or change until the sink takes it
    a_hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_pixel_x) && $stable(out_pixel_y)
            && $stable(out_depth) && $stable(out_color) && $stable(out_compare_depth))
        else begin
            $error("pixel dropped or changed while out_ready was low");
            fail_count++;
        end

    a_on_screen: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (out_pixel_x < SCREEN_W) && (out_pixel_y < SCREEN_H))
        else begin
            $error("pixel at %0d,%0d lies outside the screen", out_pixel_x, out_pixel_y);
            fail_count++;
        end

endmodule

`default_nettype wire

/* render_manager.sv */
`timescale 1ns/10ps
`default_nettype none

module render_manager (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              begin_frame,
    input  wire logic [render_pkg::COLOR_BITS-1:0] fill_color,
    input  wire logic                              fill_valid,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_x0,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_y0,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_x1,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_y1,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_x2,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_y2,
    input  wire logic [render_pkg::COLOR_BITS-1:0] tri_color,
    input  wire logic [render_pkg::DEPTH_BITS-1:0] tri_depth,
    input  wire logic                              triangle_valid,
    input  wire logic                              out_ready,
    output logic                                   fill_ready,
    output logic                                   triangle_ready,
    output logic      [render_pkg::COORD_BITS-1:0] out_pixel_x,
    output logic      [render_pkg::COORD_BITS-1:0] out_pixel_y,
    output logic      [render_pkg::DEPTH_BITS-1:0] out_depth,
    output logic      [render_pkg::COLOR_BITS-1:0] out_color,
    output logic                                   out_compare_depth,
    output logic                                   out_valid,
    output logic                                   busy
);
    import render_pkg::*;

    logic [1:0]            state, state_next;
    logic                  fill_start;
    logic [COLOR_BITS-1:0] fill_color_reg;
    logic                  in_triangle;

    logic                  filler_busy, filler_valid;
    logic [COORD_BITS-1:0] filler_x, filler_y;
    logic [COLOR_BITS-1:0] filler_color;

    logic                  setup_valid, setup_in_ready, setup_busy;
    logic [COORD_BITS-1:0] span_x_min, span_x_max, span_y_min, span_y_max;
    logic [COORD_BITS-1:0] span_x0, span_y0, span_x1, span_y1, span_x2, span_y2;
    logic [COLOR_BITS-1:0] span_color;
    logic [DEPTH_BITS-1:0] span_depth;
    logic                  span_valid, span_ready;

    logic                  walker_busy, walker_valid;
    logic [COORD_BITS-1:0] walker_x, walker_y;
    logic [COLOR_BITS-1:0] walker_color;
    logic [DEPTH_BITS-1:0] walker_depth;

    assign fill_ready = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_color_reg <= '0;  // black screen for the fill after reset
        end else if (fill_valid) begin
            fill_color_reg <= fill_color;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_FILL;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        fill_start = 1'b0;
        case (state)
            ST_FILL: begin
                fill_start = 1'b1;
                state_next = ST_FILL_WAIT;
            end
            ST_FILL_WAIT: if (!filler_busy) state_next = ST_TRIANGLE;
            ST_TRIANGLE:  if (begin_frame) state_next = ST_FILL;
            default:      state_next = ST_FILL;
        endcase
    end

    assign in_triangle    = (state == ST_TRIANGLE);
    assign setup_valid    = in_triangle && triangle_valid;
    assign triangle_ready = in_triangle && setup_in_ready;  // closed while the screen clears
    assign busy           = in_triangle ? (setup_busy || walker_busy) : filler_busy;

    // the walker is idle outside TRIANGLE, so the filler owns the port there
    assign out_pixel_x       = in_triangle ? walker_x : filler_x;
    assign out_pixel_y       = in_triangle ? walker_y : filler_y;
    assign out_depth         = in_triangle ? walker_depth : DEPTH_FAR;
    assign out_color         = in_triangle ? walker_color : filler_color;
    assign out_compare_depth = in_triangle;
    assign out_valid         = in_triangle ? walker_valid : filler_valid;

    screen_filler u_filler (
        .clk(clk), .rst(rst), .fill_start(fill_start), .fill_color(fill_color_reg),
        .out_ready(out_ready), .busy(filler_busy), .out_pixel_x(filler_x),
        .out_pixel_y(filler_y), .out_color(filler_color), .out_valid(filler_valid)
    );

    triangle_setup u_setup (
        .clk(clk), .rst(rst),
        .tri_x0(tri_x0), .tri_y0(tri_y0), .tri_x1(tri_x1), .tri_y1(tri_y1),
        .tri_x2(tri_x2), .tri_y2(tri_y2), .tri_color(tri_color), .tri_depth(tri_depth),
        .in_valid(setup_valid), .span_ready(span_ready),
        .in_ready(setup_in_ready), .busy(setup_busy),
        .span_x_min(span_x_min), .span_x_max(span_x_max),
        .span_y_min(span_y_min), .span_y_max(span_y_max),
        .span_x0(span_x0), .span_y0(span_y0), .span_x1(span_x1), .span_y1(span_y1),
        .span_x2(span_x2), .span_y2(span_y2),
        .span_color(span_color), .span_depth(span_depth), .span_valid(span_valid)
    );

    edge_walker u_walker (
        .clk(clk), .rst(rst),
        .span_x_min(span_x_min), .span_x_max(span_x_max),
        .span_y_min(span_y_min), .span_y_max(span_y_max),
        .span_x0(span_x0), .span_y0(span_y0), .span_x1(span_x1), .span_y1(span_y1),
        .span_x2(span_x2), .span_y2(span_y2),
        .span_color(span_color), .span_depth(span_depth), .span_valid(span_valid),
        .out_ready(out_ready), .span_ready(span_ready), .busy(walker_busy),
        .out_pixel_x(walker_x), .out_pixel_y(walker_y),
        .out_color(walker_color), .out_depth(walker_depth), .out_valid(walker_valid)
    );

endmodule

`default_nettype wire

/* edge_walker.sv */
`timescale 1ns/10ps
`default_nettype none

module edge_walker (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_x_min,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_x_max,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_y_min,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_y_max,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_x0,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_y0,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_x1,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_y1,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_x2,
    input  wire logic [render_pkg::COORD_BITS-1:0] span_y2,
    input  wire logic [render_pkg::COLOR_BITS-1:0] span_color,
    input  wire logic [render_pkg::DEPTH_BITS-1:0] span_depth,
    input  wire logic                              span_valid,
    input  wire logic                              out_ready,
    output logic                                   span_ready,
    output logic                                   busy,
    output logic      [render_pkg::COORD_BITS-1:0] out_pixel_x,
    output logic      [render_pkg::COORD_BITS-1:0] out_pixel_y,
    output logic      [render_pkg::COLOR_BITS-1:0] out_color,
    output logic      [render_pkg::DEPTH_BITS-1:0] out_depth,
    output logic                                   out_valid
);
    import render_pkg::*;

    logic [COORD_BITS-1:0]       vx [3];
    logic [COORD_BITS-1:0]       vy [3];
    logic signed [EDGE_BITS-1:0] e_init [3];
    logic signed [EDGE_BITS-1:0] e_cur [3];
    logic signed [EDGE_BITS-1:0] e_row [3];
    logic signed [EDGE_BITS-1:0] step_x [3];
    logic signed [EDGE_BITS-1:0] step_y [3];
    logic [COORD_BITS-1:0]       x_min, x_max, y_max;
    logic                        active;
    logic                        covered;
    logic                        advance;
    logic                        row_end;
    logic                        last;

    // edge i runs from vertex i to vertex i+1, all evaluated at the top left box corner
    always_comb begin
        vx[0] = span_x0;
        vy[0] = span_y0;
        vx[1] = span_x1;
        vy[1] = span_y1;
        vx[2] = span_x2;
        vy[2] = span_y2;
        for (int i = 0; i < 3; i++) begin
            e_init[i] = edge_value(vx[i], vy[i], vx[(i+1)%3], vy[(i+1)%3],
                                   span_x_min, span_y_min);
        end
    end

    assign span_ready = !active;
    assign busy       = active;

    assign covered   = !e_cur[0][EDGE_BITS-1] && !e_cur[1][EDGE_BITS-1] && !e_cur[2][EDGE_BITS-1];
    assign out_valid = active && covered;
    assign advance   = active && (!covered || out_ready);  // empty positions cost one cycle
    assign row_end   = (out_pixel_x == x_max);
    assign last      = row_end && (out_pixel_y == y_max);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
        end else if (span_valid && span_ready) begin
            active <= 1'b1;
        end else if (advance && last) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (span_valid && span_ready) begin
            out_pixel_x <= span_x_min;
            out_pixel_y <= span_y_min;
            x_min       <= span_x_min;
            x_max       <= span_x_max;
            y_max       <= span_y_max;
            out_color   <= span_color;
            out_depth   <= span_depth;
            for (int i = 0; i < 3; i++) begin
                e_cur[i]  <= e_init[i];
                e_row[i]  <= e_init[i];
                step_x[i] <= EDGE_BITS'(vy[i]) - EDGE_BITS'(vy[(i+1)%3]);
                step_y[i] <= EDGE_BITS'(vx[(i+1)%3]) - EDGE_BITS'(vx[i]);
            end
        end else if (advance && !last) begin
            if (row_end) begin
                out_pixel_x <= x_min;
                out_pixel_y <= out_pixel_y + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    e_row[i] <= e_row[i] + step_y[i];
                    e_cur[i] <= e_row[i] + step_y[i];  // restart from the row start, one row down
                end
            end else begin
                out_pixel_x <= out_pixel_x + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    e_cur[i] <= e_cur[i] + step_x[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* triangle_setup.sv */
`timescale 1ns/10ps
`default_nettype none

module triangle_setup (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_x0,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_y0,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_x1,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_y1,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_x2,
    input  wire logic [render_pkg::COORD_BITS-1:0] tri_y2,
    input  wire logic [render_pkg::COLOR_BITS-1:0] tri_color,
    input  wire logic [render_pkg::DEPTH_BITS-1:0] tri_depth,
    input  wire logic                              in_valid,
    input  wire logic                              span_ready,
    output logic                                   in_ready,
    output logic                                   busy,
    output logic      [render_pkg::COORD_BITS-1:0] span_x_min,
    output logic      [render_pkg::COORD_BITS-1:0] span_x_max,
    output logic      [render_pkg::COORD_BITS-1:0] span_y_min,
    output logic      [render_pkg::COORD_BITS-1:0] span_y_max,
    output logic      [render_pkg::COORD_BITS-1:0] span_x0,
    output logic      [render_pkg::COORD_BITS-1:0] span_y0,
    output logic      [render_pkg::COORD_BITS-1:0] span_x1,
    output logic      [render_pkg::COORD_BITS-1:0] span_y1,
    output logic      [render_pkg::COORD_BITS-1:0] span_x2,
    output logic      [render_pkg::COORD_BITS-1:0] span_y2,
    output logic      [render_pkg::COLOR_BITS-1:0] span_color,
    output logic      [render_pkg::DEPTH_BITS-1:0] span_depth,
    output logic                                   span_valid
);
    import render_pkg::*;

    logic                        loaded;
    logic [COORD_BITS-1:0]       x0, y0, x1, y1, x2, y2;
    logic [COORD_BITS-1:0]       x_lo, x_hi, y_lo, y_hi;
    logic signed [EDGE_BITS-1:0] area;
    logic                        box_empty;
    logic                        swap;
    logic                        drop;

    assign in_ready = !loaded;
    assign busy     = loaded;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (in_valid && in_ready) begin
            loaded <= 1'b1;
        end else if (loaded && (drop || span_ready)) begin
            loaded <= 1'b0;  // handed to the walker or discarded
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            x0         <= tri_x0;
            y0         <= tri_y0;
            x1         <= tri_x1;
            y1         <= tri_y1;
            x2         <= tri_x2;
            y2         <= tri_y2;
            span_color <= tri_color;
            span_depth <= tri_depth;
        end
    end

    always_comb begin
        x_lo = (x0 < x1) ? x0 : x1;
        x_hi = (x0 < x1) ? x1 : x0;
        y_lo = (y0 < y1) ? y0 : y1;
        y_hi = (y0 < y1) ? y1 : y0;
        if (x2 < x_lo) x_lo = x2;
        if (x2 > x_hi) x_hi = x2;
        if (y2 < y_lo) y_lo = y2;
        if (y2 > y_hi) y_hi = y2;
        area = edge_value(x0, y0, x1, y1, x2, y2);
        // coordinates are unsigned so only the low corner can fall off the screen entirely
        box_empty = (x_lo >= SCREEN_W) || (y_lo >= SCREEN_H);
        swap = (area < 0);  // clockwise
        drop = box_empty || (area == 0) || (BACKFACE_CULLING && swap);
    end

    assign span_x_min = x_lo;
    assign span_y_min = y_lo;
    assign span_x_max = (x_hi > SCREEN_W - 1) ? COORD_BITS'(SCREEN_W - 1) : x_hi;
    assign span_y_max = (y_hi > SCREEN_H - 1) ? COORD_BITS'(SCREEN_H - 1) : y_hi;

    // swapping v1 and v2 turns a clockwise triangle counter-clockwise
    assign span_x0 = x0;
    assign span_y0 = y0;
    assign span_x1 = swap ? x2 : x1;
    assign span_y1 = swap ? y2 : y1;
    assign span_x2 = swap ? x1 : x2;
    assign span_y2 = swap ? y1 : y2;

    assign span_valid = loaded && !drop;

endmodule

`default_nettype wire

/* screen_filler.sv */
`timescale 1ns/10ps
`default_nettype none

module screen_filler (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              fill_start,
    input  wire logic [render_pkg::COLOR_BITS-1:0] fill_color,
    input  wire logic                              out_ready,
    output logic                                   busy,
    output logic      [render_pkg::COORD_BITS-1:0] out_pixel_x,
    output logic      [render_pkg::COORD_BITS-1:0] out_pixel_y,
    output logic      [render_pkg::COLOR_BITS-1:0] out_color,
    output logic                                   out_valid
);
    import render_pkg::*;

    logic row_end;
    logic last;

    assign row_end = (out_pixel_x == COORD_BITS'(SCREEN_W - 1));
    assign last    = row_end && (out_pixel_y == COORD_BITS'(SCREEN_H - 1));

    assign busy = fill_start || out_valid;  // covers the start cycle before valid rises

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid   <= 1'b0;
            out_pixel_x <= '0;
            out_pixel_y <= '0;
        end else if (fill_start) begin
            out_valid   <= 1'b1;
            out_pixel_x <= '0;
            out_pixel_y <= '0;
        end else if (out_valid && out_ready) begin
            if (last) begin
                out_valid <= 1'b0;  // whole screen written
            end else if (row_end) begin
                out_pixel_x <= '0;
                out_pixel_y <= out_pixel_y + 1'b1;
            end else begin
                out_pixel_x <= out_pixel_x + 1'b1;
            end
        end
    end

    // colour is captured once so a new fill colour cannot tear the frame
    always_ff @(posedge clk) begin
        if (fill_start) begin
            out_color <= fill_color;
        end
    end

endmodule

`default_nettype wire

/* render_pkg.sv */
`default_nettype none

package render_pkg;

    // screen geometry in whole pixels
    localparam int SCREEN_W = 16;
    localparam int SCREEN_H = 12;

    localparam int COORD_BITS = 8;   // unsigned pixel and vertex coordinates
    localparam int COLOR_BITS = 12;  // 4 bits each of r, g, b
    localparam int DEPTH_BITS = 16;

    // the fill leaves every pixel at the far plane
    localparam logic [DEPTH_BITS-1:0] DEPTH_FAR = '1;

    // wide enough for any edge value or doubled area with 8-bit coordinates
    localparam int EDGE_BITS = 18;

    // 1 drops clockwise triangles, 0 flips them to counter-clockwise and draws them
    localparam bit BACKFACE_CULLING = 1'b1;

    // frame sequencing states of the manager
    localparam logic [1:0] ST_FILL      = 2'd0;
    localparam logic [1:0] ST_FILL_WAIT = 2'd1;
    localparam logic [1:0] ST_TRIANGLE  = 2'd2;

    // E(a,b,p) = (bx-ax)(py-ay) - (by-ay)(px-ax), positive when p lies left of a->b
    function automatic logic signed [EDGE_BITS-1:0] edge_value(
        input logic [COORD_BITS-1:0] ax,
        input logic [COORD_BITS-1:0] ay,
        input logic [COORD_BITS-1:0] bx,
        input logic [COORD_BITS-1:0] by,
        input logic [COORD_BITS-1:0] px,
        input logic [COORD_BITS-1:0] py
    );
        logic signed [EDGE_BITS-1:0] dx_ab;
        logic signed [EDGE_BITS-1:0] dy_ab;
        logic signed [EDGE_BITS-1:0] dx_ap;
        logic signed [EDGE_BITS-1:0] dy_ap;
        dx_ab = EDGE_BITS'(bx) - EDGE_BITS'(ax);
        dy_ab = EDGE_BITS'(by) - EDGE_BITS'(ay);
        dx_ap = EDGE_BITS'(px) - EDGE_BITS'(ax);
        dy_ap = EDGE_BITS'(py) - EDGE_BITS'(ay);
        return dx_ab * dy_ap - dy_ab * dx_ap;  // the true value always fits in EDGE_BITS
    endfunction

endpackage

`default_nettype wire
